//--- fpVecMul.f
source/fpVecMulPkg.sv
source/laneIf.sv
source/readIf.sv
source/wbOperandBank.sv
source/fp16MulLane.sv
source/fp16ResultCollector.sv
source/fpVecMulTop.sv
dv/fpVecMulTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the fpVecMul testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module fpVecMulTb \
	-f fpVecMul.f \
	-o fpVecMulSim

# A $fatal in the testbench gives a nonzero exit status
./obj_dir/fpVecMulSim

//--- dv/fpVecMulTb.sv
`timescale 1ns/1ns

module fpVecMulTb;
	localparam int LANES = 4;
	// About 3300 two-cycle transfers including status polls take near 7000 cycles
	localparam int TIMEOUT_CYCLES = 20000;

	logic clk = 1'b0;
	logic rst;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic wbAck;
	logic [fpVecMulPkg::WB_ADDR_W-1:0] wbAdr;
	logic [fpVecMulPkg::WB_DATA_W-1:0] wbDatW;
	logic [fpVecMulPkg::WB_DATA_W-1:0] wbDatR;
	logic [31:0] rdVal; // Last read data
	logic [15:0] opA [LANES];
	logic [15:0] opB [LANES];
	int seed = 32'h4eec_9cda;
	int cycles = 0;

	fpVecMulTop #(.NUM_LANES(LANES)) UUT (
		.clk(clk),
		.rst(rst),
		.i_wbCyc(wbCyc),
		.i_wbStb(wbStb),
		.i_wbWe(wbWe),
		.i_wbAdr(wbAdr),
		.i_wbDatW(wbDatW),
		.o_wbDatR(wbDatR),
		.o_wbAck(wbAck)
	);

	always #4 clk = ~clk; // 8 ns period

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("*** TEST FAILED ***");
			$fatal(1, "Timeout after %0d cycles, the tests did not finish", cycles);
		end
	end

	// Expected fp16 product and input flags from the arithmetic rules
	function automatic logic [15:0] refMulHalf(input logic [15:0] a, input logic [15:0] b,
			output logic [4:0] flags);
		int ea;
		int eb;
		int e;
		logic [21:0] p;
		logic [9:0] m;
		logic s, aNan, bNan, aInf, bInf, aZero, bZero;
		ea = int'(a[14:10]);
		eb = int'(b[14:10]);
		aNan = (ea == 31) && (|a[9:0]);
		bNan = (eb == 31) && (|b[9:0]);
		aInf = (ea == 31) && !(|a[9:0]);
		bInf = (eb == 31) && !(|b[9:0]);
		aZero = (ea == 0); // Subnormal reads as zero
		bZero = (eb == 0);
		flags = {aNan | bNan | aInf | bInf, aNan, bNan, aInf, bInf};
		s = a[15] ^ b[15];
		if (aNan || bNan || (aInf && bZero) || (bInf && aZero)) return 16'h7E00;
		if (aInf || bInf) return {s, 15'h7C00};
		if (aZero || bZero) return {s, 15'h0000};
		p = 22'({1'b1, a[9:0]}) * 22'({1'b1, b[9:0]});
		e = ea + eb - 15;
		if (p[21]) begin
			e++;
			m = p[20:11]; // Truncate
		end else begin
			m = p[19:10];
		end
		if (e > 30) return {s, 15'h7C00};
		if (e <= 0) return {s, 15'h0000};
		return {s, 5'(e), m};
	endfunction

	function automatic logic [31:0] refHalfToSingle(input logic [15:0] h);
		if (h[14:10] == 5'd0) return {h[15], 31'd0};
		if (h[14:10] == 5'h1f) return {h[15], 8'hff, h[9:0], 13'd0};
		return {h[15], 8'(int'(h[14:10]) + 112), h[9:0], 13'd0};
	endfunction

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// One classic cycle with inputs changed on the falling edge
	task automatic wbAccess(input logic we, input logic [7:0] adr, input logic [31:0] dat);
		@(negedge clk);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = adr;
		wbDatW = dat;
		@(negedge clk);
		while (!wbAck) @(negedge clk);
		rdVal = wbDatR; // Valid with ack
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic wbWrite(input logic [7:0] adr, input logic [31:0] dat);
		wbAccess(1'b1, adr, dat);
	endtask

	task automatic wbRead(input logic [7:0] adr, output logic [31:0] dat);
		wbAccess(1'b0, adr, 32'd0);
		dat = rdVal;
	endtask

	task automatic writeLane(input int i);
		wbWrite(fpVecMulPkg::ADDR_OPER_BASE + 8'(fpVecMulPkg::LANE_STRIDE * i), {opA[i], opB[i]});
	endtask

	task automatic startCmd();
		wbWrite(fpVecMulPkg::ADDR_CMD, 32'(fpVecMulPkg::CMD_START));
	endtask

	// Poll until done and nothing in flight
	task automatic waitIdle();
		logic [31:0] st;
		wbRead(fpVecMulPkg::ADDR_STATUS, st);
		while (st != 32'h2) wbRead(fpVecMulPkg::ADDR_STATUS, st);
	endtask

	task automatic checkLanes(input logic zeros);
		logic [31:0] got;
		logic [15:0] prod;
		logic [4:0] flags;
		for (int i = 0; i < LANES; i++) begin
			prod = refMulHalf(opA[i], opB[i], flags);
			wbRead(fpVecMulPkg::ADDR_RES_BASE + 8'(fpVecMulPkg::LANE_STRIDE * i), got);
			checkEq($sformatf("result[%0d]", i), got, zeros ? 32'd0 : refHalfToSingle(prod));
			wbRead(fpVecMulPkg::ADDR_FLAG_BASE + 8'(fpVecMulPkg::LANE_STRIDE * i), got);
			checkEq($sformatf("flags[%0d]", i), got, zeros ? 32'd0 : {27'd0, flags});
		end
	endtask

	task automatic runCurrent();
		for (int i = 0; i < LANES; i++) writeLane(i);
		startCmd();
		waitIdle();
		checkLanes(1'b0);
	endtask

	// Lane 3 sits in the top bits
	task automatic runSet(input logic [3:0][15:0] a, input logic [3:0][15:0] b);
		for (int i = 0; i < LANES; i++) begin
			opA[i] = a[i];
			opB[i] = b[i];
		end
		runCurrent();
	endtask

	task automatic randOps();
		logic [31:0] r;
		for (int i = 0; i < LANES; i++) begin
			r = $random(seed);
			opA[i] = {r[31], 5'(1 + r[20:16] % 30), r[9:0]}; // Normal exponents only
			r = $random(seed);
			opB[i] = {r[31], 5'(1 + r[20:16] % 30), r[9:0]};
		end
	endtask

	initial begin
		rst = 1'b1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatW = '0;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		wbRead(fpVecMulPkg::ADDR_STATUS, rdVal);
		checkEq("status", rdVal, 32'd0);
		checkLanes(1'b1);
		repeat (200) begin
			randOps();
			runCurrent();
		end
		// NaN x 1, inf x 0, inf x -2, subnormal x 1
		runSet({16'h0001, 16'h7C00, 16'h7C00, 16'h7C01}, {16'h3C00, 16'hC000, 16'h0000, 16'h3C00});
		// -0 x 1, negative NaN, subnormal x -inf, 5 x 0
		runSet({16'h4500, 16'h0200, 16'hBC00, 16'h8000}, {16'h0000, 16'hFC00, 16'hFE00, 16'h3C00});
		// Overflow and underflow in both signs
		runSet({16'h8C00, 16'hC000, 16'h0400, 16'h7BFF}, {16'h0C00, 16'h7800, 16'h0400, 16'h7BFF});
		// Three starts with lane 0 changing between them
		randOps();
		for (int i = 0; i < LANES; i++) writeLane(i);
		startCmd();
		for (int k = 0; k < 2; k++) begin
			opA[0] = opA[0] ^ (16'h0155 << k); // Mantissa only
			writeLane(0);
			startCmd();
		end
		waitIdle();
		checkLanes(1'b0);
		wbWrite(fpVecMulPkg::ADDR_CMD, 32'(fpVecMulPkg::CMD_CLEAR));
		wbRead(fpVecMulPkg::ADDR_STATUS, rdVal);
		checkEq("status", rdVal, 32'd0);
		checkLanes(1'b1);
		wbRead(8'h08, rdVal);
		checkEq("unmapped 0x08", rdVal, 32'd0);
		wbRead(8'h40, rdVal);
		checkEq("unmapped 0x40", rdVal, 32'd0);
		wbRead(8'hFC, rdVal);
		checkEq("unmapped 0xFC", rdVal, 32'd0);
		$display("*** TEST PASSED ***");
		$finish;
	end
endmodule

//--- source/fpVecMulTop.sv
`timescale 1ns/1ns

module fpVecMulTop #(
	parameter int NUM_LANES = 4 // 1 to 4
) (
	input logic clk,
	input logic rst,
	input logic i_wbCyc,
	input logic i_wbStb,
	input logic i_wbWe,
	input logic [fpVecMulPkg::WB_ADDR_W-1:0] i_wbAdr,
	input logic [fpVecMulPkg::WB_DATA_W-1:0] i_wbDatW,
	output logic [fpVecMulPkg::WB_DATA_W-1:0] o_wbDatR,
	output logic o_wbAck
);
	laneIf lanes [NUM_LANES] ();
	readIf rdBus ();
	logic clearPulse; // CMD_CLEAR
	logic done;

	wbOperandBank #(.NUM_LANES(NUM_LANES)) uBank (
		.clk(clk),
		.rst(rst),
		.i_wbCyc(i_wbCyc),
		.i_wbStb(i_wbStb),
		.i_wbWe(i_wbWe),
		.i_wbAdr(i_wbAdr),
		.i_wbDatW(i_wbDatW),
		.o_wbDatR(o_wbDatR),
		.o_wbAck(o_wbAck),
		.o_lanes(lanes),
		.o_rd(rdBus),
		.i_done(done),
		.o_clear(clearPulse)
	);

	for (genvar g = 0; g < NUM_LANES; g++) begin : gLane
		fp16MulLane uLane (.clk(clk), .rst(rst), .io_lane(lanes[g]));
	end

	fp16ResultCollector #(.NUM_LANES(NUM_LANES)) uCollect (
		.clk(clk),
		.rst(rst),
		.i_clear(clearPulse),
		.i_lanes(lanes),
		.o_rd(rdBus),
		.o_done(done)
	);
endmodule

//--- source/fp16ResultCollector.sv
`timescale 1ns/1ns

module fp16ResultCollector #(
	parameter int NUM_LANES = 4
) (
	input logic clk,
	input logic rst,
	input logic i_clear,
	laneIf.drain i_lanes [NUM_LANES],
	readIf.respond o_rd,
	output logic o_done
);
	localparam int HW = fpVecMulPkg::HALF_W;
	localparam int EW = fpVecMulPkg::HALF_EXP_W;
	localparam int MW = fpVecMulPkg::HALF_MAN_W;
	localparam int SW = fpVecMulPkg::SINGLE_W;
	localparam int SMW = 23; // fp32 mantissa
	localparam int SEW = 8;
	localparam int REBIAS = 127 - fpVecMulPkg::HALF_BIAS; // 112

	logic [NUM_LANES-1:0] laneValid;
	logic [HW-1:0] laneProd [NUM_LANES];
	fpVecMulPkg::flagVec_t laneFlags [NUM_LANES];
	logic [SW-1:0] results [NUM_LANES];
	fpVecMulPkg::flagVec_t flagRegs [NUM_LANES];
	logic laneIssue;
	logic [2:0] inFlight; // Up to four beats

	// Exact widening, products are never subnormal
	function automatic logic [SW-1:0] halfToSingle(input logic [HW-1:0] h);
		logic [SEW-1:0] e;
		e = SEW'(h[MW +: EW]) + SEW'(REBIAS);
		if (h[HW-2:0] == '0) begin
			return {h[HW-1], {(SW - 1){1'b0}}}; // Signed zero
		end
		if (&h[MW +: EW]) begin
			return {h[HW-1], {SEW{1'b1}}, h[MW-1:0], {(SMW - MW){1'b0}}}; // Inf or NaN
		end
		return {h[HW-1], e, h[MW-1:0], {(SMW - MW){1'b0}}};
	endfunction

	for (genvar g = 0; g < NUM_LANES; g++) begin : gDrain
		assign laneValid[g] = i_lanes[g].prodValid;
		assign laneProd[g] = i_lanes[g].product;
		assign laneFlags[g] = i_lanes[g].flags;
	end

	assign laneIssue = i_lanes[0].issueValid; // Lanes issue together

	always_ff @(posedge clk) begin
		if (rst) begin
			inFlight <= '0;
		end else begin
			inFlight <= inFlight + 3'(laneIssue) - 3'(laneValid[0]);
		end
	end

	// High from the issue cycle on
	assign o_rd.busy = (inFlight != '0) || laneIssue;

	always_ff @(posedge clk) begin
		if (rst || i_clear) begin
			o_done <= 1'b0;
			for (int i = 0; i < NUM_LANES; i++) begin
				results[i] <= '0;
				flagRegs[i] <= '0;
			end
		end else begin
			if (laneValid[0]) o_done <= 1'b1;
			for (int i = 0; i < NUM_LANES; i++) begin
				if (laneValid[i]) begin
					results[i] <= halfToSingle(laneProd[i]); // Last beat wins
					flagRegs[i] <= laneFlags[i];
				end
			end
		end
	end

	always_comb begin
		o_rd.rdData = '0;
		if (int'(o_rd.rdLane) < NUM_LANES) begin
			if (o_rd.rdKind == fpVecMulPkg::RD_FLAGS) begin
				o_rd.rdData = fpVecMulPkg::WB_DATA_W'(flagRegs[o_rd.rdLane]);
			end else begin
				o_rd.rdData = results[o_rd.rdLane];
			end
		end
	end

	lanesInStep: assert property (@(posedge clk) disable iff (rst)
		(laneValid == '0) || (&laneValid));
endmodule

//--- source/fp16MulLane.sv
`timescale 1ns/1ns

module fp16MulLane (
	input logic clk,
	input logic rst,
	laneIf.lane io_lane
);
	localparam int HW = fpVecMulPkg::HALF_W;
	localparam int EW = fpVecMulPkg::HALF_EXP_W;
	localparam int MW = fpVecMulPkg::HALF_MAN_W;
	localparam int PW = 2 * (MW + 1); // Full 11x11 product
	localparam int XW = EW + 3; // Signed exponent after bias removal
	localparam logic signed [XW-1:0] BIAS_S = XW'(fpVecMulPkg::HALF_BIAS);
	localparam logic signed [XW-1:0] EMAX_S = XW'(2 ** EW - 2); // Largest finite exponent

	logic [4:1] vld; // Valid bit per stage

	// Prep classification
	logic aExpMax, bExpMax;
	logic aNaN, bNaN, aInf, bInf, aZero, bZero;
	logic nanIn;

	// Stage registers
	logic sA1, sB1, nan1, inf1, zero1;
	logic [EW-1:0] eA1, eB1;
	logic [MW:0] mA1, mB1; // Hidden bit included
	fpVecMulPkg::flagVec_t flg1, flg2, flg3, flg4;
	logic s2, nan2, inf2, zero2;
	logic [EW:0] eSum2;
	logic [PW-1:0] mP2;
	logic s3, nan3, inf3, zero3;
	logic signed [XW-1:0] eN3;
	logic [MW-1:0] man3;
	logic ovf;
	logic [HW-1:0] prodOut, prod4;

	assign aExpMax = &io_lane.opA[MW +: EW];
	assign bExpMax = &io_lane.opB[MW +: EW];
	assign aNaN = aExpMax && (|io_lane.opA[MW-1:0]);
	assign bNaN = bExpMax && (|io_lane.opB[MW-1:0]);
	assign aInf = aExpMax && !(|io_lane.opA[MW-1:0]);
	assign bInf = bExpMax && !(|io_lane.opB[MW-1:0]);
	assign aZero = !(|io_lane.opA[MW +: EW]); // Subnormals count as zero
	assign bZero = !(|io_lane.opB[MW +: EW]);
	assign nanIn = aNaN || bNaN || (aInf && bZero) || (bInf && aZero); // Inf x 0 too

	assign ovf = mP2[PW-1]; // Product in [2,4)

	// Output select
	always_comb begin
		if (nan3) begin
			prodOut = fpVecMulPkg::CANON_NAN_H;
		end else if (inf3 || eN3 > EMAX_S) begin
			prodOut = {s3, {EW{1'b1}}, {MW{1'b0}}}; // Saturate
		end else if (zero3 || eN3 <= 0) begin
			prodOut = {s3, {(HW - 1){1'b0}}}; // Flush
		end else begin
			prodOut = {s3, eN3[EW-1:0], man3};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vld <= '0;
		end else begin
			vld <= {vld[3:1], io_lane.issueValid};
		end
	end

	always_ff @(posedge clk) begin
		// Prep
		sA1 <= io_lane.opA[HW-1];
		sB1 <= io_lane.opB[HW-1];
		eA1 <= io_lane.opA[MW +: EW];
		eB1 <= io_lane.opB[MW +: EW];
		mA1 <= {1'b1, io_lane.opA[MW-1:0]};
		mB1 <= {1'b1, io_lane.opB[MW-1:0]};
		nan1 <= nanIn;
		inf1 <= (aInf || bInf) && !nanIn;
		zero1 <= (aZero || bZero) && !nanIn;
		flg1 <= '{aNaN || bNaN || aInf || bInf, aNaN, bNaN, aInf, bInf};
		// Execute
		s2 <= sA1 ^ sB1;
		eSum2 <= {1'b0, eA1} + {1'b0, eB1};
		mP2 <= mA1 * mB1;
		{nan2, inf2, zero2} <= {nan1, inf1, zero1};
		flg2 <= flg1;
		// Normalize, truncating the low bits
		s3 <= s2;
		man3 <= ovf ? mP2[PW-2 -: MW] : mP2[PW-3 -: MW];
		eN3 <= $signed({2'b00, eSum2}) + $signed(XW'(ovf)) - BIAS_S;
		{nan3, inf3, zero3} <= {nan2, inf2, zero2};
		flg3 <= flg2;
		// Output
		prod4 <= prodOut;
		flg4 <= flg3;
	end

	assign io_lane.prodValid = vld[4];
	assign io_lane.product = prod4;
	assign io_lane.flags = flg4;

	fourCycleLatency: assert property (@(posedge clk) disable iff (rst)
		io_lane.prodValid == $past(io_lane.issueValid, 4));
endmodule

//--- source/wbOperandBank.sv
`timescale 1ns/1ns

module wbOperandBank #(
	parameter int NUM_LANES = 4
) (
	input logic clk,
	input logic rst,
	input logic i_wbCyc,
	input logic i_wbStb,
	input logic i_wbWe,
	input logic [fpVecMulPkg::WB_ADDR_W-1:0] i_wbAdr,
	input logic [fpVecMulPkg::WB_DATA_W-1:0] i_wbDatW,
	output logic [fpVecMulPkg::WB_DATA_W-1:0] o_wbDatR,
	output logic o_wbAck,
	laneIf.feed o_lanes [NUM_LANES],
	readIf.request o_rd,
	input logic i_done,
	output logic o_clear
);
	localparam int AW = fpVecMulPkg::WB_ADDR_W;
	localparam int DW = fpVecMulPkg::WB_DATA_W;
	localparam int HW = fpVecMulPkg::HALF_W;
	localparam int LW = fpVecMulPkg::LANE_W;
	localparam int WIN_SPAN = fpVecMulPkg::MAX_LANES * fpVecMulPkg::LANE_STRIDE;
	localparam int LANE_LSB = $clog2(fpVecMulPkg::LANE_STRIDE);
	localparam logic [AW-1:0] WIN_MASK = ~(AW'(WIN_SPAN - 1)); // Strips lane offset

	fpVecMulPkg::bankState_e state;
	fpVecMulPkg::cmdOp_e cmdOp;
	logic [DW-1:0] operands [NUM_LANES]; // Packed a/b pairs
	logic [DW-1:0] rdMux;
	logic [AW-1:0] winBase;
	logic [LW-1:0] laneSel;
	logic laneOk;
	logic req;
	logic issueValid;

	// New transfer only while idle, so each cyc/stb gets one ack
	assign req = i_wbCyc && i_wbStb && (state == fpVecMulPkg::ST_IDLE);
	assign o_wbAck = (state == fpVecMulPkg::ST_ACK);
	assign cmdOp = fpVecMulPkg::cmdOp_e'(i_wbDatW[1:0]);

	assign winBase = i_wbAdr & WIN_MASK;
	assign laneSel = i_wbAdr[LANE_LSB +: LW];
	assign laneOk = int'(laneSel) < NUM_LANES; // Lanes above NUM_LANES are unmapped

	// Collector window decode
	assign o_rd.rdLane = laneSel;
	assign o_rd.rdKind = (winBase == fpVecMulPkg::ADDR_FLAG_BASE) ?
		fpVecMulPkg::RD_FLAGS : fpVecMulPkg::RD_RESULT;

	always_comb begin
		rdMux = '0; // Unmapped reads return zero
		if (i_wbAdr == fpVecMulPkg::ADDR_STATUS) begin
			rdMux[1:0] = {i_done, o_rd.busy};
		end else if (laneOk && winBase == fpVecMulPkg::ADDR_OPER_BASE) begin
			rdMux = operands[laneSel];
		end else if (laneOk && (winBase == fpVecMulPkg::ADDR_RES_BASE ||
				winBase == fpVecMulPkg::ADDR_FLAG_BASE)) begin
			rdMux = o_rd.rdData;
		end
	end

	// Ack FSM plus command pulses, all land in the ack cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fpVecMulPkg::ST_IDLE;
			issueValid <= 1'b0;
			o_clear <= 1'b0;
		end else begin
			issueValid <= 1'b0;
			o_clear <= 1'b0;
			case (state)
				fpVecMulPkg::ST_IDLE: begin
					if (req) begin
						state <= fpVecMulPkg::ST_ACK;
						if (i_wbWe && i_wbAdr == fpVecMulPkg::ADDR_CMD) begin
							issueValid <= (cmdOp == fpVecMulPkg::CMD_START);
							o_clear <= (cmdOp == fpVecMulPkg::CMD_CLEAR);
						end
					end
				end
				default: state <= fpVecMulPkg::ST_IDLE; // Ack lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_LANES; i++) begin
				operands[i] <= '0;
			end
		end else if (req && i_wbWe && laneOk && winBase == fpVecMulPkg::ADDR_OPER_BASE) begin
			operands[laneSel] <= i_wbDatW;
		end
	end

	// Read data registered with the ack
	always_ff @(posedge clk) begin
		if (req) begin
			o_wbDatR <= rdMux;
		end
	end

	// Every lane sees the same start pulse
	for (genvar g = 0; g < NUM_LANES; g++) begin : gFeed
		assign o_lanes[g].issueValid = issueValid;
		assign o_lanes[g].opA = operands[g][HW +: HW];
		assign o_lanes[g].opB = operands[g][0 +: HW];
	end

	ackFollowsReq: assert property (@(posedge clk) disable iff (rst)
		$rose(o_wbAck) |-> $past(i_wbCyc && i_wbStb));
endmodule

//--- source/readIf.sv
`timescale 1ns/1ns

// Combinational read window into the collector
interface readIf;
	logic [fpVecMulPkg::LANE_W-1:0] rdLane;
	fpVecMulPkg::readKind_e rdKind;
	logic [fpVecMulPkg::WB_DATA_W-1:0] rdData;
	logic busy; // Beats still in flight

	modport request (output rdLane, rdKind, input rdData, busy);
	modport respond (input rdLane, rdKind, output rdData, busy);
endinterface

//--- source/laneIf.sv
`timescale 1ns/1ns

// One operand beat in, one product beat out
interface laneIf;
	logic issueValid; // Single cycle per start
	logic [fpVecMulPkg::HALF_W-1:0] opA;
	logic [fpVecMulPkg::HALF_W-1:0] opB;
	logic prodValid; // Four cycles after issueValid
	logic [fpVecMulPkg::HALF_W-1:0] product;
	fpVecMulPkg::flagVec_t flags;

	modport feed (output issueValid, opA, opB);
	modport lane (input issueValid, opA, opB, output prodValid, product, flags);
	// No back-pressure; issueValid visible so the collector can count in-flight beats
	modport drain (input issueValid, prodValid, product, flags);
endinterface

//--- source/fpVecMulPkg.sv
package fpVecMulPkg;
	// fp16 operand format
	localparam int HALF_W = 16;
	localparam int HALF_EXP_W = 5;
	localparam int HALF_MAN_W = 10;
	localparam int HALF_BIAS = 15;
	localparam int SINGLE_W = 32;
	localparam logic [HALF_W-1:0] CANON_NAN_H = 16'h7E00; // Quiet NaN, zero payload

	// Wishbone widths
	localparam int WB_ADDR_W = 8; // Byte addressed
	localparam int WB_DATA_W = 32;

	// Address map
	localparam logic [WB_ADDR_W-1:0] ADDR_CMD = 8'h00; // Write only
	localparam logic [WB_ADDR_W-1:0] ADDR_STATUS = 8'h04; // bit0 busy, bit1 done
	localparam logic [WB_ADDR_W-1:0] ADDR_OPER_BASE = 8'h10; // a in 31:16, b in 15:0
	localparam logic [WB_ADDR_W-1:0] ADDR_RES_BASE = 8'h20;
	localparam logic [WB_ADDR_W-1:0] ADDR_FLAG_BASE = 8'h30;
	localparam int LANE_STRIDE = 4;
	localparam int MAX_LANES = 4;
	localparam int LANE_W = $clog2(MAX_LANES);

	// Input exception vector, MSB first
	typedef struct packed {
		logic anySpecial;
		logic aNaN;
		logic bNaN;
		logic aInf;
		logic bInf;
	} flagVec_t;

	typedef enum logic [1:0] {CMD_NOP = 2'd0, CMD_START = 2'd1, CMD_CLEAR = 2'd2} cmdOp_e;
	typedef enum logic [1:0] {ST_IDLE = 2'd0, ST_ACK = 2'd1} bankState_e;
	typedef enum logic {RD_RESULT = 1'b0, RD_FLAGS = 1'b1} readKind_e;
endpackage
